// File: logic/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// byte address into the backing memory
`define CACHE_ADDR_W      16

// line geometry
`define CACHE_LINE_BYTES  16
`define CACHE_LINE_W      128

// address split, tag above index above offset
`define CACHE_OFFSET_W    4
`define CACHE_INDEX_W     5
`define CACHE_TAG_W       7
`define CACHE_NUM_LINES   32

// log2 of the access size in bytes
`define CACHE_SIZE_W      3

`endif

// File: logic/cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

   typedef logic [`CACHE_ADDR_W-1:0]     addr_t;
   typedef logic [`CACHE_LINE_W-1:0]     line_t;
   typedef logic [`CACHE_LINE_BYTES-1:0] byte_mask_t;
   typedef logic [`CACHE_OFFSET_W-1:0]   offset_t;
   typedef logic [`CACHE_INDEX_W-1:0]    index_t;
   typedef logic [`CACHE_TAG_W-1:0]      tag_t;
   // 0..4 select 1, 2, 4, 8, 16 bytes
   typedef logic [`CACHE_SIZE_W-1:0]     size_code_t;

   // one state set for both directions, direction kept in a separate flop
   typedef enum logic [2:0]
   {
      IDLE,
      LOOKUP,
      EVICT,
      FILL,
      DONE
   } cache_state_e;

endpackage

// File: logic/cache_req_align.sv
`include "cache_defines.svh"

module cache_req_align
(
   input  cache_pkg::offset_t    offset,
   input  cache_pkg::size_code_t size,
   input  cache_pkg::line_t      data_write,
   output cache_pkg::byte_mask_t write_mask,
   output cache_pkg::line_t      write_line
);

   // run of byte enables starting at byte 0
   cache_pkg::byte_mask_t base_mask;

   // bit shift for the write data, offset in bytes times eight
   logic [$clog2(`CACHE_LINE_W)-1:0] bit_shift;

   // size code expands to 1, 2, 4, 8 or 16 ones
   always_comb
   begin
      case (size)
         3'd0:    base_mask = 16'h0001;
         3'd1:    base_mask = 16'h0003;
         3'd2:    base_mask = 16'h000f;
         3'd3:    base_mask = 16'h00ff;
         // codes above 4 treated as a whole line
         default: base_mask = 16'hffff;
      endcase
   end

   // move the run up to the addressed byte
   // bytes past the end of the line fall off
   assign write_mask = base_mask << offset;

   assign bit_shift = {offset, 3'b000};

   // request byte 0 lands on the addressed byte
   // zeros shift in below it
   assign write_line = data_write << bit_shift;

endmodule

// File: logic/cache_ctrl.sv
module cache_ctrl
(
   input  logic clk,
   input  logic rst_n,
   input  logic enable,
   input  logic rw,
   input  logic hit,
   input  logic victim_dirty,
   input  logic bus_r,
   output logic ready,
   output logic data_we,
   output logic fill_we,
   output logic bus_en,
   output logic bus_wr,
   output logic evicting
);

   cache_pkg::cache_state_e state_q;
   cache_pkg::cache_state_e state_d;

   // direction of the request in flight, 1 means write
   logic rw_q;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q <= cache_pkg::IDLE;
         rw_q    <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         // latch direction when a new request is accepted
         if (state_q == cache_pkg::IDLE && enable)
            rw_q <= rw;
      end
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         cache_pkg::IDLE:
         begin
            if (enable)
               state_d = cache_pkg::LOOKUP;
         end
         cache_pkg::LOOKUP:
         begin
            // miss with a dirty victim goes out to the bus first
            if (hit)
               state_d = cache_pkg::DONE;
            else if (victim_dirty)
               state_d = cache_pkg::EVICT;
            else
               state_d = cache_pkg::FILL;
         end
         cache_pkg::EVICT:
         begin
            // held until the bus takes the victim line
            if (bus_r)
               state_d = cache_pkg::FILL;
         end
         cache_pkg::FILL:
         begin
            // back to lookup, which hits now
            if (bus_r)
               state_d = cache_pkg::LOOKUP;
         end
         cache_pkg::DONE:
            state_d = cache_pkg::IDLE;
         default:
            state_d = cache_pkg::IDLE;
      endcase
   end

   // outputs straight from state
   assign ready    = (state_q == cache_pkg::DONE);
   assign data_we  = (state_q == cache_pkg::DONE) && rw_q;
   // fill line written only in the cycle the bus returns it
   assign fill_we  = (state_q == cache_pkg::FILL) && bus_r;
   assign bus_en   = (state_q == cache_pkg::EVICT) || (state_q == cache_pkg::FILL);
   assign bus_wr   = (state_q == cache_pkg::EVICT);
   assign evicting = (state_q == cache_pkg::EVICT);

endmodule

// File: logic/cache_tag_store.sv
`include "cache_defines.svh"

module cache_tag_store
(
   input  logic              clk,
   input  logic              rst_n,
   input  cache_pkg::index_t index,
   input  cache_pkg::tag_t   tag,
   input  logic              fill_we,
   input  logic              data_we,
   output logic              hit,
   output logic              victim_dirty,
   output cache_pkg::tag_t   victim_tag
);

   // one bit per line
   logic [`CACHE_NUM_LINES-1:0] valid_q;
   logic [`CACHE_NUM_LINES-1:0] dirty_q;

   // stored tags
   cache_pkg::tag_t tag_q [`CACHE_NUM_LINES];

   logic tag_match;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         valid_q <= '0;
         dirty_q <= '0;
      end
      else if (fill_we)
      begin
         // fresh line from memory is clean
         valid_q[index] <= 1'b1;
         dirty_q[index] <= 1'b0;
      end
      else if (data_we)
         dirty_q[index] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (fill_we)
         tag_q[index] <= tag;
   end

   // combinational lookup of the indexed entry
   assign victim_tag   = tag_q[index];
   assign tag_match    = (tag_q[index] == tag);
   assign hit          = valid_q[index] && tag_match;
   // other tag held with modified data, has to be written back
   assign victim_dirty = valid_q[index] && dirty_q[index] && !tag_match;

endmodule

// File: logic/cache_data_array.sv
`include "cache_defines.svh"

module cache_data_array
(
   input  logic                  clk,
   input  cache_pkg::index_t     index,
   input  cache_pkg::byte_mask_t write_mask,
   input  cache_pkg::line_t      write_line,
   input  logic                  data_we,
   input  logic                  fill_we,
   input  cache_pkg::line_t      fill_line,
   output cache_pkg::line_t      line
);

   cache_pkg::line_t mem [`CACHE_NUM_LINES];

   always_ff @(posedge clk)
   begin
      // whole line from the bus on a fill
      if (fill_we)
         mem[index] <= fill_line;
      else if (data_we)
      begin
         // processor write, masked bytes only
         for (int b = 0; b < `CACHE_LINE_BYTES; b++)
         begin
            if (write_mask[b])
               mem[index][b*8 +: 8] <= write_line[b*8 +: 8];
         end
      end
   end

   // async read of the selected line
   assign line = mem[index];

endmodule

// File: logic/cache_read_align.sv
`include "cache_defines.svh"

module cache_read_align
(
   input  cache_pkg::line_t   line,
   input  cache_pkg::offset_t offset,
   input  cache_pkg::addr_t   address,
   input  cache_pkg::tag_t    victim_tag,
   input  logic               evicting,
   output cache_pkg::line_t   data_read,
   output cache_pkg::addr_t   bus_addr
);

   cache_pkg::index_t req_index;

   // offset in bits for the output shift
   logic [$clog2(`CACHE_LINE_W)-1:0] bit_shift;

   assign bit_shift = {offset, 3'b000};

   // addressed byte moves down to byte 0, zeros fill above
   assign data_read = line >> bit_shift;

   assign req_index = address[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

   // write-back goes to where the victim came from
   // otherwise the line of the current request
   assign bus_addr = evicting ?
                     {victim_tag, req_index, {`CACHE_OFFSET_W{1'b0}}} :
                     {address[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};

endmodule

// File: logic/cache_top.sv
`include "cache_defines.svh"

module cache_top
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  enable,
   input  logic                  rw,
   input  cache_pkg::addr_t      address,
   input  cache_pkg::size_code_t size,
   input  cache_pkg::line_t      data_write,
   output cache_pkg::line_t      data_read,
   output logic                  ready,
   output logic                  bus_en,
   output logic                  bus_wr,
   output cache_pkg::addr_t      bus_addr,
   output cache_pkg::line_t      bus_write,
   input  logic                  bus_r,
   input  cache_pkg::line_t      bus_read
);

   // address fields
   cache_pkg::offset_t    offset;
   cache_pkg::index_t     index;
   cache_pkg::tag_t       tag;

   // request side to storage
   cache_pkg::byte_mask_t write_mask;
   cache_pkg::line_t      write_line;

   // controller strobes
   logic data_we;
   logic fill_we;
   logic evicting;

   // lookup results
   logic            hit;
   logic            victim_dirty;
   cache_pkg::tag_t victim_tag;

   // indexed line, feeds both processor and bus
   cache_pkg::line_t line;

   assign offset = address[`CACHE_OFFSET_W-1:0];
   assign index  = address[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
   assign tag    = address[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

   // victim data leaves straight from the array
   assign bus_write = line;

   cache_req_align u_req_align
   (
      .offset     (offset),
      .size       (size),
      .data_write (data_write),
      .write_mask (write_mask),
      .write_line (write_line)
   );

   cache_ctrl u_ctrl
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .enable       (enable),
      .rw           (rw),
      .hit          (hit),
      .victim_dirty (victim_dirty),
      .bus_r        (bus_r),
      .ready        (ready),
      .data_we      (data_we),
      .fill_we      (fill_we),
      .bus_en       (bus_en),
      .bus_wr       (bus_wr),
      .evicting     (evicting)
   );

   cache_tag_store u_tag_store
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .index        (index),
      .tag          (tag),
      .fill_we      (fill_we),
      .data_we      (data_we),
      .hit          (hit),
      .victim_dirty (victim_dirty),
      .victim_tag   (victim_tag)
   );

   // fill data comes directly off the bus
   cache_data_array u_data_array
   (
      .clk        (clk),
      .index      (index),
      .write_mask (write_mask),
      .write_line (write_line),
      .data_we    (data_we),
      .fill_we    (fill_we),
      .fill_line  (bus_read),
      .line       (line)
   );

   cache_read_align u_read_align
   (
      .line       (line),
      .offset     (offset),
      .address    (address),
      .victim_tag (victim_tag),
      .evicting   (evicting),
      .data_read  (data_read),
      .bus_addr   (bus_addr)
   );

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen
(
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk   = 1'b0;
      rst_n = 1'b0;
      // low through 16 rising edges, released away from the edge
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

   // period of 20
   always #10 clk = ~clk;

endmodule

// File: verification/tb_cache.sv
`include "cache_defines.svh"

module tb_cache;

   localparam int CLK_PERIOD   = 20;
   // accesses issued by all tests together
   // read miss, read hit, five write and read pairs, write miss pair,
   // two evictions, read hit, clean miss
   localparam int NUM_ACCESSES = 1 + 1 + 5 * 2 + 2 + 2 + 1 + 1;
   // miss with eviction at the longest bus delays plus margin
   localparam int WORST_CYCLES = 20;
   localparam int TIMEOUT      = (16 + NUM_ACCESSES * WORST_CYCLES) * CLK_PERIOD;

   logic clk;
   logic rst_n;

   logic                  enable;
   logic                  rw;
   cache_pkg::addr_t      address;
   cache_pkg::size_code_t size;
   cache_pkg::line_t      data_write;
   cache_pkg::line_t      data_read;
   logic                  ready;
   logic                  bus_en;
   logic                  bus_wr;
   cache_pkg::addr_t      bus_addr;
   cache_pkg::line_t      bus_write;
   logic                  bus_r;
   cache_pkg::line_t      bus_read;

   // backing memory seen by the bus
   logic [7:0] mem [0:65535];
   // expected view through the cache
   logic [7:0] shadow [0:65535];

   // bus transfer log
   int               bus_reads;
   int               bus_writes;
   cache_pkg::addr_t last_read_addr;
   cache_pkg::addr_t last_write_addr;

   logic [31:0] lfsr_q = 32'ha3ad_1b61;

   tb_clock_gen u_clock_gen
   (
      .clk   (clk),
      .rst_n (rst_n)
   );

   cache_top UUT
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .enable     (enable),
      .rw         (rw),
      .address    (address),
      .size       (size),
      .data_write (data_write),
      .data_read  (data_read),
      .ready      (ready),
      .bus_en     (bus_en),
      .bus_wr     (bus_wr),
      .bus_addr   (bus_addr),
      .bus_write  (bus_write),
      .bus_r      (bus_r),
      .bus_read   (bus_read)
   );

   // fibonacci LFSR with taps 32 22 2 1
   // one step per bit taken
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         r      = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic cache_pkg::line_t random_line();
      return {lfsr_bits(32), lfsr_bits(32), lfsr_bits(32), lfsr_bits(32)};
   endfunction

   // bytes from the offset to the end of the line
   // zeros above them
   function automatic cache_pkg::line_t expected_read(input cache_pkg::addr_t a);
      cache_pkg::line_t r;
      int               off;
      r   = '0;
      off = a[3:0];
      for (int b = 0; b < `CACHE_LINE_BYTES; b++)
      begin
         if (off + b < `CACHE_LINE_BYTES)
            r[b*8 +: 8] = shadow[{a[15:4], 4'h0} + off + b];
      end
      return r;
   endfunction

   // whole line as the bus memory holds it
   function automatic cache_pkg::line_t memory_line(input cache_pkg::addr_t a);
      cache_pkg::line_t r;
      for (int b = 0; b < `CACHE_LINE_BYTES; b++)
         r[b*8 +: 8] = mem[{a[15:4], 4'h0} + b];
      return r;
   endfunction

   task automatic check_equal(input logic [127:0] got, input logic [127:0] exp,
                              input string what);
      if (got !== exp)
      begin
         $display("Error at time %0t: %s, got %h expected %h", $time, what, got, exp);
         $display("Simulation failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // 1 << sz bytes of wdata land at a in the expected memory
   task automatic shadow_write(input cache_pkg::addr_t a, input cache_pkg::size_code_t sz,
                               input cache_pkg::line_t wdata);
      for (int b = 0; b < (1 << sz); b++)
      begin
         if (a[3:0] + b < `CACHE_LINE_BYTES)
            shadow[a + b] = wdata[b*8 +: 8];
      end
   endtask

   // one request held until ready
   // cycles counted from the enable edge
   task automatic access(input logic wr, input cache_pkg::addr_t a,
                         input cache_pkg::size_code_t sz, input cache_pkg::line_t wdata,
                         output cache_pkg::line_t rdata, output int cycles);
      @(negedge clk);
      enable     = 1'b1;
      rw         = wr;
      address    = a;
      size       = sz;
      data_write = wdata;
      cycles     = 0;
      do
      begin
         @(negedge clk);
         cycles++;
      end
      while (!ready);
      rdata = data_read;
      // address and data stay put for the write at the end of DONE
      enable = 1'b0;
      if (wr)
         shadow_write(a, sz, wdata);
   endtask

   task automatic reset_state_quiet();
      @(negedge clk);
      check_equal(ready, 1'b0, "ready after reset");
      check_equal(bus_en, 1'b0, "bus_en after reset");
      check_equal(bus_wr, 1'b0, "bus_wr after reset");
   endtask

   task automatic read_miss_fill(input cache_pkg::addr_t a);
      cache_pkg::line_t rdata;
      int               cycles;
      int               reads0;
      int               writes0;
      reads0  = bus_reads;
      writes0 = bus_writes;
      access(1'b0, a, 3'd0, '0, rdata, cycles);
      check_equal(bus_reads, reads0 + 1, "bus reads on read miss");
      check_equal(bus_writes, writes0, "bus writes on read miss");
      check_equal(last_read_addr, {a[15:4], 4'h0}, "fill address");
      check_equal(rdata, expected_read(a), "read miss data");
   endtask

   task automatic read_hit_no_bus(input cache_pkg::addr_t a);
      cache_pkg::line_t rdata;
      int               cycles;
      int               reads0;
      int               writes0;
      reads0  = bus_reads;
      writes0 = bus_writes;
      access(1'b0, a, 3'd0, '0, rdata, cycles);
      check_equal(bus_reads + bus_writes, reads0 + writes0, "bus activity on read hit");
      check_equal(cycles, 2, "read hit latency");
      check_equal(rdata, expected_read(a), "read hit data");
   endtask

   // every size code once at an offset aligned to the size
   task automatic masked_write_hits(input cache_pkg::addr_t base);
      cache_pkg::line_t rdata;
      cache_pkg::line_t wdata;
      cache_pkg::addr_t a;
      int               cycles;
      int               transfers0;
      for (int sz = 0; sz <= 4; sz++)
      begin
         transfers0 = bus_reads + bus_writes;
         a          = base | (lfsr_bits(4) & (16 - (1 << sz)));
         wdata      = random_line();
         access(1'b1, a, sz, wdata, rdata, cycles);
         check_equal(bus_reads + bus_writes, transfers0, "bus activity on write hit");
         check_equal(cycles, 2, "write hit latency");
         access(1'b0, base, 3'd0, '0, rdata, cycles);
         check_equal(rdata, expected_read(base), "line after masked write");
      end
   endtask

   task automatic write_miss_merge(input cache_pkg::addr_t a, input cache_pkg::size_code_t sz);
      cache_pkg::line_t rdata;
      int               cycles;
      int               reads0;
      int               writes0;
      reads0  = bus_reads;
      writes0 = bus_writes;
      access(1'b1, a, sz, random_line(), rdata, cycles);
      check_equal(bus_reads, reads0 + 1, "bus reads on write miss");
      check_equal(bus_writes, writes0, "bus writes on clean write miss");
      check_equal(last_read_addr, {a[15:4], 4'h0}, "write miss fill address");
      access(1'b0, {a[15:4], 4'h0}, 3'd0, '0, rdata, cycles);
      check_equal(rdata, expected_read({a[15:4], 4'h0}), "line after write miss");
   endtask

   // a maps onto the dirty line at victim with another tag
   task automatic dirty_eviction(input cache_pkg::addr_t a, input cache_pkg::addr_t victim);
      cache_pkg::line_t rdata;
      int               cycles;
      int               reads0;
      int               writes0;
      reads0  = bus_reads;
      writes0 = bus_writes;
      access(1'b0, a, 3'd0, '0, rdata, cycles);
      check_equal(bus_writes, writes0 + 1, "bus writes on dirty eviction");
      check_equal(last_write_addr, victim, "write-back address");
      check_equal(memory_line(victim), expected_read(victim), "written-back line");
      check_equal(bus_reads, reads0 + 1, "bus reads after eviction");
      check_equal(last_read_addr, {a[15:4], 4'h0}, "fill address after eviction");
      check_equal(rdata, expected_read(a), "read data after eviction");
   endtask

   // bus memory answers each transfer after 0 to 3 extra cycles
   initial
   begin : bus_model
      int delay;
      bus_r           = 1'b0;
      bus_read        = '0;
      bus_reads       = 0;
      bus_writes      = 0;
      last_read_addr  = '0;
      last_write_addr = '0;
      forever
      begin
         @(negedge clk);
         bus_r = 1'b0;
         if (bus_en === 1'b1)
         begin
            delay = lfsr_bits(2);
            repeat (delay) @(negedge clk);
            check_equal(bus_addr[3:0], 4'h0, "bus address alignment");
            if (bus_wr)
            begin
               for (int b = 0; b < `CACHE_LINE_BYTES; b++)
                  mem[bus_addr + b] = bus_write[b*8 +: 8];
               last_write_addr = bus_addr;
               bus_writes++;
            end
            else
            begin
               bus_read       = memory_line(bus_addr);
               last_read_addr = bus_addr;
               bus_reads++;
            end
            bus_r = 1'b1;
         end
      end
   end

   initial
   begin
      #(TIMEOUT);
      $display("Simulation failed");
      $fatal(1, "timeout, the DUT stopped answering before the tests were done");
   end

   initial
   begin
      enable     = 1'b0;
      rw         = 1'b0;
      address    = '0;
      size       = '0;
      data_write = '0;
      // pattern mixes every address bit
      for (int a = 0; a < 65536; a++)
      begin
         mem[a]    = a[7:0] ^ (a[15:8] * 8'h1d) ^ 8'h5a;
         shadow[a] = mem[a];
      end
      wait (rst_n === 1'b1);
      reset_state_quiet();
      read_miss_fill(16'h1234);
      read_hit_no_bus(16'h1238);
      masked_write_hits(16'h1230);
      write_miss_merge(16'h2a48, 3'd3);
      // same index as 0x1230 and 0x2a40 with other tags
      dirty_eviction(16'h5236, 16'h1230);
      dirty_eviction(16'h6a40, 16'h2a40);
      read_hit_no_bus(16'h523f);
      // clean line at index 3 replaced without a write-back
      read_miss_fill(16'h7234);
      $display("Simulation passed");
      $finish;
   end

endmodule

// File: verilog.f
+incdir+logic
logic/cache_pkg.sv
logic/cache_req_align.sv
logic/cache_ctrl.sv
logic/cache_tag_store.sv
logic/cache_data_array.sv
logic/cache_read_align.sv
logic/cache_top.sv
verification/tb_clock_gen.sv
verification/tb_cache.sv

// File: Bender.yml
package:
  name: cache

sources:
  - include_dirs:
      - logic
    files:
      - logic/cache_pkg.sv
      - logic/cache_req_align.sv
      - logic/cache_ctrl.sv
      - logic/cache_tag_store.sv
      - logic/cache_data_array.sv
      - logic/cache_read_align.sv
      - logic/cache_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_cache.sv
